/* balance_cfg.svh */
// gains and thresholds are fixed at build time; values assume a 10-bit pitch error and 11-bit duty
`ifndef BALANCE_CFG_SVH
`define BALANCE_CFG_SVH

//////////////////////////////
// PID gains
//////////////////////////////

// proportional gain on the saturated pitch error
`define P_COEFF 14

// derivative gain on the saturated 7-bit error difference
`define D_COEFF 20

// integrator lsbs dropped to form the I term, leaves a 12-bit term
`define I_TERM_SHIFT 6

//////////////////////////////
// torque shaping
//////////////////////////////

`define LOW_TORQUE_BAND 70      // 5 * P_COEFF, below this the gain multiplier applies
`define GAIN_MULTIPLIER 15      // 1 + MIN_DUTY / LOW_TORQUE_BAND, keeps the curve continuous
`define MIN_DUTY        16'h03D4 // offset that stiffens the motor on large torques

// speed above which the rider gets the piezo warning
// a saturated speed of 0x7FF is always above it
`define OVR_SPD_LIMIT 11'h600

`endif

/* balance_cntrl.sv */
// inputs to outputs are combinational; only the PID integrator and error history are clocked
`include "balance_cfg.svh"

module balance_cntrl
  import balance_pkg::*;
  import motor_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,         // async, active low
  input  logic     vld,           // new inertial reading strobe
  input  ptch_t    ptch,          // measured pitch
  input  ld_diff_t ld_cell_diff,  // left minus right load
  input  logic     rider_off,     // clears the integrator
  input  logic     en_steer,      // steering enabled
  input  logic     pwr_up,        // drive authorized
  output spd_t     lft_spd,
  output logic     lft_rev,
  output spd_t     rght_spd,
  output logic     rght_rev,
  output logic     ovr_spd
);

  torque_t pid_cntrl;   // balance correction into the drive path

  //////////////////////////////
  // PID
  //////////////////////////////

  pitch_pid u_pid (
    .clk       (clk),
    .rst_n     (rst_n),
    .vld       (vld),
    .ptch      (ptch),
    .rider_off (rider_off),
    .pwr_up    (pwr_up),
    .pid_cntrl (pid_cntrl)
  );

  //////////////////////////////
  // steering and motors
  //////////////////////////////

  motor_drive u_drive (
    .pid_cntrl    (pid_cntrl),
    .ld_cell_diff (ld_cell_diff),
    .en_steer     (en_steer),
    .pwr_up       (pwr_up),
    .lft_spd      (lft_spd),
    .rght_spd     (rght_spd),
    .lft_rev      (lft_rev),
    .rght_rev     (rght_rev),
    .ovr_spd      (ovr_spd)
  );

endmodule

/* balance_pkg.sv */
// control path types only; all widths are two's complement and sized for the fixed gains
package balance_pkg;

  //////////////////////////////
  // pitch side
  //////////////////////////////

  // raw pitch from the inertial sensor, full 16 bits signed
  typedef logic signed [15:0] ptch_t;

  // pitch error after saturation to 10 bits
  // range -512 .. +511, anything outside is clipped
  typedef logic signed [9:0] ptch_err_t;

  // error difference over two readings, clipped to -64 .. +63
  typedef logic signed [6:0] d_diff_t;

  //////////////////////////////
  // integrator and torque
  //////////////////////////////

  // integral accumulator
  // holds its value when the next sum would overflow
  typedef logic signed [17:0] integ_t;

  // PID correction and per motor torque
  // P tops out near 7154, I at +-2048, D at +-1280
  // plus the steering term this still fits in 16 bits
  typedef logic signed [15:0] torque_t;

endpackage

/* motor_drive.sv */
// steering uses ld_cell_diff / 8 rounded toward minus infinity; ovr_spd is strictly above limit
`include "balance_cfg.svh"

module motor_drive
  import balance_pkg::*;
  import motor_pkg::*;
(
  input  torque_t  pid_cntrl,     // balance correction
  input  ld_diff_t ld_cell_diff,  // left minus right load
  input  logic     en_steer,      // steering allowed
  input  logic     pwr_up,
  output spd_t     lft_spd,
  output spd_t     rght_spd,
  output logic     lft_rev,
  output logic     rght_rev,
  output logic     ovr_spd        // to the piezo warning
);

  torque_t steer;        // scaled load difference
  torque_t lft_torque;
  torque_t rght_torque;

  //////////////////////////////
  // steering mix
  //////////////////////////////

  assign steer = torque_t'(ld_cell_diff >>> 3);   // arithmetic shift, sign extended

  // more load on the left turns left: slow left, speed up right
  assign lft_torque  = en_steer ? (pid_cntrl - steer) : pid_cntrl;
  assign rght_torque = en_steer ? (pid_cntrl + steer) : pid_cntrl;

  //////////////////////////////
  // per motor shaping
  //////////////////////////////

  torque_shaper u_lft (
    .torque (lft_torque),
    .pwr_up (pwr_up),
    .spd    (lft_spd),
    .rev    (lft_rev)
  );

  torque_shaper u_rght (
    .torque (rght_torque),
    .pwr_up (pwr_up),
    .spd    (rght_spd),
    .rev    (rght_rev)
  );

  // either wheel too fast warns the rider
  assign ovr_spd = (lft_spd > `OVR_SPD_LIMIT) || (rght_spd > `OVR_SPD_LIMIT);

endmodule

/* motor_pkg.sv */
// drive path types only; speed is unsigned magnitude, direction travels as a separate rev bit
package motor_pkg;

  //////////////////////////////
  // drive side
  //////////////////////////////

  // left minus right load cell reading
  // divided by 8 before it steers the torques
  typedef logic signed [11:0] ld_diff_t;

  // motor speed (duty magnitude) for one wheel
  // saturates at 0x7FF, zero when not powered up
  typedef logic [10:0] spd_t;

endpackage

/* pitch_pid.sv */
// integrator and error history update only on a vld strobe; rider_off wins over vld
`include "balance_cfg.svh"

module pitch_pid
  import balance_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    vld,        // one-cycle strobe, new inertial reading
  input  ptch_t   ptch,       // measured pitch
  input  logic    rider_off,  // no weight on the load cells
  input  logic    pwr_up,     // drive authorized
  output torque_t pid_cntrl   // P + I + D correction
);

  ptch_err_t         ptch_err;    // saturated pitch error
  torque_t           p_term;
  integ_t            integ;       // integral accumulator
  integ_t            err_ext;     // error sign extended to integrator width
  integ_t            integ_nxt;
  logic              integ_ovfl;
  torque_t           i_term;
  ptch_err_t         err_hist1;   // error from the last valid reading
  ptch_err_t         err_hist2;   // error from two valid readings ago
  logic signed [10:0] d_raw;      // one bit wider so the difference never wraps
  d_diff_t           d_sat;
  torque_t           d_term;

  //////////////////////////////
  // pitch error and P term
  //////////////////////////////

  always_comb begin
    if (ptch > 16'sd511)
      ptch_err = 10'sh1FF;          // clip to most positive
    else if (ptch < -16'sd512)
      ptch_err = 10'sh200;          // clip to most negative
    else
      ptch_err = ptch[9:0];
  end

  assign p_term = torque_t'(ptch_err * `P_COEFF); // max 14 * 511, fits easily

  //////////////////////////////
  // integrator
  //////////////////////////////

  assign err_ext   = integ_t'(ptch_err);          // signed cast, sign extends
  assign integ_nxt = integ + err_ext;

  // overflow only when both operands agree in sign and the sum does not
  assign integ_ovfl = (integ[17] == err_ext[17]) && (integ_nxt[17] != integ[17]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      integ <= '0;
    else if (rider_off)
      integ <= '0;                  // rider stepped off, drop the windup
    else if (vld && !integ_ovfl)
      integ <= integ_nxt;           // freeze on overflow
  end

  // upper 12 bits only; held at zero until powered up so nothing lurches on enable
  assign i_term = pwr_up ? torque_t'(integ >>> `I_TERM_SHIFT) : '0;

  //////////////////////////////
  // derivative
  //////////////////////////////

  // two-deep history of the error, shifted per valid reading
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_hist1 <= '0;
      err_hist2 <= '0;
    end else if (vld) begin
      err_hist1 <= ptch_err;
      err_hist2 <= err_hist1;
    end
  end

  assign d_raw = $signed({ptch_err[9], ptch_err}) - $signed({err_hist2[9], err_hist2});

  always_comb begin
    if (d_raw > 11'sd63)
      d_sat = 7'sh3F;
    else if (d_raw < -11'sd64)
      d_sat = 7'sh40;
    else
      d_sat = d_raw[6:0];
  end

  assign d_term = torque_t'(d_sat * `D_COEFF);    // -1280 .. +1260

  // all three terms are sign extended to 16 bits, no overflow possible
  assign pid_cntrl = p_term + i_term + d_term;

  //////////////////////////////
  // checks
  //////////////////////////////

  // without a strobe or a clear the accumulator must hold
  a_integ_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!vld && !rider_off) |=> $stable(integ));

  // clear lands on the very next edge whatever vld does
  a_integ_clear: assert property (@(posedge clk) disable iff (!rst_n)
    rider_off |=> (integ == '0));

endmodule

/* sources.f */
+incdir+.
balance_pkg.sv
motor_pkg.sv
pitch_pid.sv
torque_shaper.sv
motor_drive.sv
balance_cntrl.sv
tb_balance_cntrl.sv

/* tb_balance_cntrl.sv */
// self-checking testbench; the model tracks integrator and error history on its own, 100 ns clock
`include "balance_cfg.svh"

module tb_balance_cntrl
  import balance_pkg::*;
  import motor_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  // cycles per test, the watchdog is sized from these
  localparam integer RESET_CYCLES = 8;
  localparam integer N_RESET      = 4;
  localparam integer N_PD         = 200;
  localparam integer N_INTEG      = 150 + 300 + 50;
  localparam integer N_STEER      = 150;
  localparam integer N_PWR        = 40 + 1 + 30 + 1 + 20;
  localparam integer N_OVR        = 1 + 101 + 101 + 10;
  localparam integer TOTAL_CYCLES = RESET_CYCLES + N_RESET + N_PD + N_INTEG + N_STEER
                                    + N_PWR + N_OVR;
  localparam integer MARGIN_NS    = 5000;

  logic     clk;
  logic     rst_n;
  logic     vld;
  ptch_t    ptch;
  ld_diff_t ld_cell_diff;
  logic     rider_off;
  logic     en_steer;
  logic     pwr_up;
  spd_t     lft_spd;
  logic     lft_rev;
  spd_t     rght_spd;
  logic     rght_rev;
  logic     ovr_spd;

  integer seed = 42331;
  integer errors = 0;
  string  test_name = "reset";
  logic   check_en = 1'b0;        // compare only once reset is released

  // reference model state
  integer m_integ = 0;
  integer m_h1 = 0;
  integer m_h2 = 0;
  integer freeze_cnt = 0;          // strobes where the sum would have overflowed

  // seen by the compare process
  integer ovr_hits = 0;
  integer sat_hits = 0;

  balance_cntrl DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .vld          (vld),
    .ptch         (ptch),
    .ld_cell_diff (ld_cell_diff),
    .rider_off    (rider_off),
    .en_steer     (en_steer),
    .pwr_up       (pwr_up),
    .lft_spd      (lft_spd),
    .lft_rev      (lft_rev),
    .rght_spd     (rght_spd),
    .rght_rev     (rght_rev),
    .ovr_spd      (ovr_spd)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;           // 100 ns period

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic integer clip(input integer v, input integer lo, input integer hi);
    if (v > hi)
      return hi;
    else if (v < lo)
      return lo;
    return v;
  endfunction

  function automatic integer pitch_error(input integer p);
    return clip(p, -512, 511);     // 10-bit signed error
  endfunction

  // small torques get the gain, large ones get the offset away from zero
  function automatic integer shape_duty(input integer t);
    integer md;
    integer mag;
    md  = `MIN_DUTY;
    mag = (t < 0) ? -t : t;
    if (mag >= `LOW_TORQUE_BAND)
      return (t < 0) ? t - md : t + md;
    return t * `GAIN_MULTIPLIER;
  endfunction

  function automatic logic [10:0] speed_of(input integer shaped, input logic pwr);
    integer mag;
    mag = (shaped < 0) ? -shaped : shaped;
    if (!pwr)
      return 11'd0;
    else if (mag > 2047)
      return 11'h7FF;              // saturated
    return mag[10:0];
  endfunction

  // packed as {lft_spd, lft_rev, rght_spd, rght_rev, ovr_spd}
  function automatic logic [24:0] expected_outputs(input integer p, input integer ld,
                                                   input logic en, input logic pwr,
                                                   input integer integ, input integer h2);
    integer      err;
    integer      i_part;
    integer      d_part;
    integer      pid;
    integer      st;
    integer      lt;
    integer      rt;
    integer      ls;
    integer      rs;
    integer      lim;
    logic [10:0] lspd;
    logic [10:0] rspd;
    err    = pitch_error(p);
    i_part = pwr ? (integ >>> `I_TERM_SHIFT) : 0;
    d_part = clip(err - h2, -64, 63) * `D_COEFF;
    pid    = err * `P_COEFF + i_part + d_part;
    st     = ld >>> 3;             // floor divide by 8
    lt     = en ? pid - st : pid;
    rt     = en ? pid + st : pid;
    ls     = shape_duty(lt);
    rs     = shape_duty(rt);
    lspd   = speed_of(ls, pwr);
    rspd   = speed_of(rs, pwr);
    lim    = `OVR_SPD_LIMIT;
    return {lspd, (ls < 0), rspd, (rs < 0), (lspd > lim) || (rspd > lim)};
  endfunction

  // model state follows the same strobe, clear and freeze rules as the PID
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_integ <= 0;
      m_h1    <= 0;
      m_h2    <= 0;
    end else begin
      if (rider_off)
        m_integ <= 0;                                  // clear beats vld
      else if (vld) begin
        if (m_integ + pitch_error(ptch) > 131071 || m_integ + pitch_error(ptch) < -131072)
          freeze_cnt <= freeze_cnt + 1;                // hold on overflow
        else
          m_integ <= m_integ + pitch_error(ptch);
      end
      if (vld) begin
        m_h1 <= pitch_error(ptch);
        m_h2 <= m_h1;
      end
    end
  end

  //////////////////////////////
  // compare, 1 ns before each rising edge
  //////////////////////////////

  always begin : compare
    logic [24:0] exp_vec;
    @(negedge clk);
    #49;
    if (check_en) begin
      exp_vec = expected_outputs(ptch, ld_cell_diff, en_steer, pwr_up, m_integ, m_h2);
      if (lft_spd !== exp_vec[24:14]) begin
        $display("CHECK FAILED %s lft_spd expected 0x%0h actual 0x%0h",
                 test_name, exp_vec[24:14], lft_spd);
        errors = errors + 1;
      end
      if (lft_rev !== exp_vec[13]) begin
        $display("CHECK FAILED %s lft_rev expected %0b actual %0b",
                 test_name, exp_vec[13], lft_rev);
        errors = errors + 1;
      end
      if (rght_spd !== exp_vec[12:2]) begin
        $display("CHECK FAILED %s rght_spd expected 0x%0h actual 0x%0h",
                 test_name, exp_vec[12:2], rght_spd);
        errors = errors + 1;
      end
      if (rght_rev !== exp_vec[1]) begin
        $display("CHECK FAILED %s rght_rev expected %0b actual %0b",
                 test_name, exp_vec[1], rght_rev);
        errors = errors + 1;
      end
      if (ovr_spd !== exp_vec[0]) begin
        $display("CHECK FAILED %s ovr_spd expected %0b actual %0b",
                 test_name, exp_vec[0], ovr_spd);
        errors = errors + 1;
      end
      // powered down means no drive at all
      if (!pwr_up && (lft_spd !== 11'd0 || rght_spd !== 11'd0 || ovr_spd !== 1'b0)) begin
        $display("CHECK FAILED %s pwr_off lft/rght/ovr expected 0x0/0x0/0 actual 0x%0h/0x%0h/%0b",
                 test_name, lft_spd, rght_spd, ovr_spd);
        errors = errors + 1;
      end
      if (ovr_spd === 1'b1)
        ovr_hits = ovr_hits + 1;
      if (lft_spd === 11'h7FF || rght_spd === 11'h7FF)
        sat_hits = sat_hits + 1;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // one cycle of inputs, applied on the falling edge
  task automatic apply_inputs(input integer p, input integer ld, input logic v,
                              input logic off, input logic st, input logic pwr);
    @(negedge clk);
    ptch         = p;
    ld_cell_diff = ld;
    vld          = v;
    rider_off    = off;
    en_steer     = st;
    pwr_up       = pwr;
  endtask

  initial begin : stimulus
    integer i;
    integer p;
    integer ovr_before;
    integer sat_before;
    rst_n        = 1'b0;
    vld          = 1'b0;
    ptch         = '0;
    ld_cell_diff = '0;
    rider_off    = 1'b0;
    en_steer     = 1'b0;
    pwr_up       = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n    = 1'b1;
    check_en = 1'b1;

    test_name = "after_reset";
    for (i = 0; i < N_RESET; i++)
      apply_inputs(0, 0, 1'b0, 1'b0, 1'b0, 1'b1);

    // no strobes, so integrator and history stay zero
    test_name = "p_d_path";
    for (i = 0; i < N_PD; i++) begin
      p = ($random(seed) & 1) ? $random(seed) % 700 : $random(seed);
      apply_inputs(p, $random(seed), 1'b0, 1'b0, 1'b0, 1'b1);
    end

    test_name = "integration";
    for (i = 0; i < 150; i++)
      apply_inputs($random(seed) % 600, 0, $random(seed) & 1, 1'b0, 1'b0, 1'b1);
    for (i = 0; i < 300; i++)              // long positive run into overflow
      apply_inputs(400 + ($random(seed) & 16'h7F), 0, 1'b1, 1'b0, 1'b0, 1'b1);
    for (i = 0; i < 50; i++)
      apply_inputs(-($random(seed) & 16'h1FF), 0, $random(seed) & 1, 1'b0, 1'b0, 1'b1);
    if (freeze_cnt == 0) begin
      $display("integration: the integrator never reached overflow, freeze not exercised");
      errors = errors + 1;
    end

    test_name = "steering";
    for (i = 0; i < N_STEER; i++)
      apply_inputs($random(seed) % 300, $random(seed), $random(seed) & 1, 1'b0,
                   (i < 100), 1'b1);

    test_name = "power_rider";
    for (i = 0; i < 40; i++)
      apply_inputs($random(seed) % 800, $random(seed), $random(seed) & 1, 1'b0,
                   $random(seed) & 1, 1'b0);
    apply_inputs(300, 0, 1'b1, 1'b1, 1'b0, 1'b1);     // clear together with a strobe
    for (i = 0; i < 30; i++)
      apply_inputs($random(seed) % 500, 0, $random(seed) & 1, 1'b0, 1'b0, 1'b1);
    apply_inputs(0, 0, 1'b0, 1'b1, 1'b0, 1'b1);       // clear without a strobe
    for (i = 0; i < 20; i++)
      apply_inputs($random(seed) % 500, 0, $random(seed) & 1, 1'b0, 1'b0, 1'b1);

    test_name  = "over_speed";
    ovr_before = ovr_hits;
    sat_before = sat_hits;
    apply_inputs(0, 0, 1'b0, 1'b1, 1'b0, 1'b1);
    for (i = 0; i <= 100; i++)             // sweep up across the threshold
      apply_inputs(2 * i, 0, 1'b0, 1'b0, 1'b0, 1'b1);
    for (i = 0; i <= 100; i++)
      apply_inputs(-200 + 2 * i, 0, 1'b0, 1'b0, 1'b0, 1'b1);
    for (i = 0; i < 10; i++)
      apply_inputs(1000 + i * 37, 0, 1'b0, 1'b0, 1'b0, 1'b1);
    if (ovr_hits == ovr_before) begin
      $display("over_speed: ovr_spd never went high during the sweep");
      errors = errors + 1;
    end
    if (sat_hits == sat_before) begin
      $display("over_speed: no speed ever saturated at 0x7FF");
      errors = errors + 1;
    end

    @(posedge clk);                        // last compare is done
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  //////////////////////////////
  // watchdog
  //////////////////////////////

  initial begin
    #(TOTAL_CYCLES * 100 + MARGIN_NS);
    $display("timeout: the run did not finish in time, errors so far %0d", errors);
    $display("test failed");
    $finish;
  end

endmodule

/* torque_shaper.sv */
// purely combinational; rev follows the shaped sign even when pwr_up is low
`include "balance_cfg.svh"

module torque_shaper
  import balance_pkg::*;
  import motor_pkg::*;
(
  input  torque_t torque,   // signed torque for one motor
  input  logic    pwr_up,   // zero speed when low
  output spd_t    spd,      // duty magnitude, saturated
  output logic    rev       // 1 runs the motor in reverse
);

  logic [15:0] torque_abs;   // magnitude for the band compare
  torque_t     torque_gain;  // small torque path
  torque_t     torque_ofst;  // large torque path
  torque_t     shaped;
  logic [15:0] shaped_abs;

  //////////////////////////////
  // shaping curve
  //////////////////////////////

  assign torque_abs = torque[15] ? -torque : torque;

  // below the band, steep gain so small corrections still move the wheel
  assign torque_gain = torque_t'(torque * `GAIN_MULTIPLIER);

  // above the band, push away from zero by the minimum duty
  always_comb begin
    if (torque[15])
      torque_ofst = torque_t'(torque - `MIN_DUTY);
    else
      torque_ofst = torque_t'(torque + `MIN_DUTY);
  end

  assign shaped = (torque_abs >= `LOW_TORQUE_BAND) ? torque_ofst : torque_gain;

  //////////////////////////////
  // direction and speed
  //////////////////////////////

  assign rev        = shaped[15];                     // sign of the duty
  assign shaped_abs = shaped[15] ? -shaped : shaped;

  always_comb begin
    if (!pwr_up)
      spd = '0;                      // not authorized, motor stays still
    else if (|shaped_abs[15:11])
      spd = '1;                      // saturate to 0x7FF
    else
      spd = shaped_abs[10:0];
  end

  // no duty may leak out before the rider is authorized
  always_comb begin
    a_spd_off: assert final (pwr_up || (spd == '0));
  end

endmodule
